// File: verilog/legalizer_cfg_pkg.sv
// fixed 32-bit AXI4 geometry with 24-bit addresses and lengths; change only as a set
`default_nettype none

package legalizer_cfg_pkg;

    // ----------------------------------------------------------------------
    // bus geometry
    // ----------------------------------------------------------------------
    // data bus width in bits
    localparam int unsigned DataWidth   = 32;
    // bytes per beat
    localparam int unsigned StrbWidth   = DataWidth / 8;
    // byte offset bits inside one beat
    localparam int unsigned OffsetWidth = $clog2(StrbWidth);
    // byte address and transfer length widths
    localparam int unsigned AddrWidth   = 24;
    localparam int unsigned LenWidth    = 24;
    // AXI4 incremental burst limit in beats
    localparam int unsigned MaxBeats    = 256;
    // a page never spans more than the 4 KiB rule allows
    localparam int unsigned PageSize    = (MaxBeats * StrbWidth > 4096) ?
                                          4096 : MaxBeats * StrbWidth;
    // bits of a byte offset within a page
    localparam int unsigned PageAddrWidth = $clog2(PageSize);

    // ----------------------------------------------------------------------
    // scalar types
    // ----------------------------------------------------------------------
    typedef logic [AddrWidth-1:0]   addr_t;
    typedef logic [LenWidth-1:0]    len_t;
    typedef logic [OffsetWidth-1:0] offset_t;
    // one bit wider than a page offset so a full page fits
    typedef logic [PageAddrWidth:0] page_len_t;
    // log2 of the reduced page length in beats
    typedef logic [2:0]             llen_t;

endpackage : legalizer_cfg_pkg

`default_nettype wire

// File: verilog/burst_pkg.sv
// field order of every struct is part of the interface; only incremental bursts are described
`default_nettype none

package burst_pkg;

    // ----------------------------------------------------------------------
    // incoming transfer
    // ----------------------------------------------------------------------
    // per transfer options
    typedef struct packed {
        // read and write split at their own boundaries
        logic                    decouple_rw;
        // shrink the virtual page of either side
        logic                    src_reduce_len;
        logic                    dst_reduce_len;
        legalizer_cfg_pkg::llen_t src_max_llen;
        legalizer_cfg_pkg::llen_t dst_max_llen;
    } xfer_opt_t;

    // one linear transfer
    typedef struct packed {
        legalizer_cfg_pkg::len_t  length;
        legalizer_cfg_pkg::addr_t src_addr;
        legalizer_cfg_pkg::addr_t dst_addr;
        xfer_opt_t                opt;
    } xfer_req_t;

    // mutable state of one side
    typedef struct packed {
        legalizer_cfg_pkg::addr_t addr;
        legalizer_cfg_pkg::len_t  length;
        logic                     valid;
    } cursor_t;

    // ----------------------------------------------------------------------
    // emitted bursts
    // ----------------------------------------------------------------------
    // address channel fields, addr is beat aligned
    typedef struct packed {
        legalizer_cfg_pkg::addr_t addr;
        logic [7:0]               len;
        logic [2:0]               size;
    } ax_req_t;

    // read data path hints
    typedef struct packed {
        legalizer_cfg_pkg::offset_t offset;
        legalizer_cfg_pkg::offset_t tailer;
    } r_dp_req_t;

    // write data path hints
    typedef struct packed {
        legalizer_cfg_pkg::offset_t offset;
        legalizer_cfg_pkg::offset_t tailer;
        logic [7:0]                 num_beats;
        logic                       is_single;
    } w_dp_req_t;

    typedef struct packed {
        ax_req_t   ax;
        r_dp_req_t r_dp;
    } r_req_t;

    // last flags the final write burst of a transfer
    typedef struct packed {
        ax_req_t   ax;
        w_dp_req_t w_dp;
        logic      last;
    } w_req_t;

endpackage : burst_pkg

`default_nettype wire

// File: verilog/side_cursor.sv
// one side only; load wins over kill and kill over enable, bytes_possible_i must not exceed bytes_to_pb_o
`default_nettype none

module side_cursor (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         load_i,
    input  legalizer_cfg_pkg::addr_t     load_addr_i,
    input  legalizer_cfg_pkg::len_t      load_len_i,
    input  logic                         ena_i,
    input  logic                         kill_i,
    input  logic                         reduce_i,
    input  legalizer_cfg_pkg::llen_t     max_llen_i,
    input  legalizer_cfg_pkg::page_len_t bytes_possible_i,
    output burst_pkg::cursor_t           cur_o,
    output legalizer_cfg_pkg::page_len_t bytes_to_pb_o,
    output legalizer_cfg_pkg::page_len_t num_bytes_o,
    output logic                         done_o
);
    import legalizer_cfg_pkg::*;

    burst_pkg::cursor_t           cur_q;
    logic [3:0]                   width_raw;
    logic [3:0]                   page_width;
    page_len_t                    page_size;
    logic [PageAddrWidth-1:0]     page_offset;

    // ----------------------------------------------------------------------
    // page boundary
    // ----------------------------------------------------------------------
    always_comb begin
        // reduced page is 2^max_llen beats, otherwise a full 256 beats
        width_raw  = 4'(OffsetWidth) + (reduce_i ? {1'b0, max_llen_i} : 4'd8);
        // never larger than the real page
        page_width = (width_raw > 4'(PageAddrWidth)) ? 4'(PageAddrWidth) : width_raw;
    end

    assign page_size = page_len_t'(1) << page_width;

    // address bits below the variable page width
    always_comb begin
        page_offset = '0;
        for (int i = 0; i < PageAddrWidth; i++) begin
            page_offset[i] = (page_width > 4'(i)) ? cur_q.addr[i] : 1'b0;
        end
    end

    // bytes left until the next boundary
    assign bytes_to_pb_o = page_size - page_offset;

    // ----------------------------------------------------------------------
    // burst size of this step
    // ----------------------------------------------------------------------
    // remaining bytes fit into what the coupler allows
    assign done_o      = (cur_q.length <= len_t'(bytes_possible_i));
    assign num_bytes_o = done_o ? cur_q.length[PageAddrWidth:0] : bytes_possible_i;

    // ----------------------------------------------------------------------
    // state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cur_q <= '0;
        end else if (load_i) begin
            cur_q.addr   <= load_addr_i;
            cur_q.length <= load_len_i;
            cur_q.valid  <= 1'b1;
        end else if (kill_i) begin
            // drop whatever is left
            cur_q <= '0;
        end else if (ena_i) begin
            if (done_o) begin
                // final burst leaves, cursor goes idle with nothing left
                cur_q.length <= '0;
                cur_q.valid  <= 1'b0;
            end else begin
                cur_q.addr   <= cur_q.addr + addr_t'(bytes_possible_i);
                cur_q.length <= cur_q.length - len_t'(bytes_possible_i);
            end
        end
    end

    assign cur_o = cur_q;

endmodule : side_cursor

`default_nettype wire

// File: verilog/burst_coupler.sv
// valid strobes follow ready combinationally, so a sink must not wait for valid before raising ready
`default_nettype none

module burst_coupler (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         valid_i,
    input  burst_pkg::xfer_opt_t         opt_i,
    input  legalizer_cfg_pkg::page_len_t r_to_pb_i,
    input  legalizer_cfg_pkg::page_len_t w_to_pb_i,
    input  logic                         r_done_i,
    input  logic                         w_done_i,
    input  logic                         r_valid_cur_i,
    input  logic                         w_valid_cur_i,
    input  logic                         r_ready_i,
    input  logic                         w_ready_i,
    input  logic                         flush_i,
    input  logic                         kill_i,
    output burst_pkg::xfer_opt_t         opt_o,
    output logic                         accept_o,
    output logic                         ready_o,
    output legalizer_cfg_pkg::page_len_t r_bytes_possible_o,
    output legalizer_cfg_pkg::page_len_t w_bytes_possible_o,
    output logic                         r_ena_o,
    output logic                         w_ena_o,
    output logic                         r_valid_o,
    output logic                         w_valid_o
);
    import legalizer_cfg_pkg::*;
    import burst_pkg::*;

    xfer_opt_t opt_q;
    page_len_t c_to_pb;
    logic      both_ready;

    // ----------------------------------------------------------------------
    // acceptance
    // ----------------------------------------------------------------------
    // both sides on their last burst and free to move
    assign ready_o  = r_done_i & w_done_i & r_ready_i & w_ready_i & ~flush_i;
    assign accept_o = ready_o & valid_i;

    // options live as long as the transfer
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            opt_q <= '0;
        end else if (accept_o) begin
            opt_q <= opt_i;
        end
    end

    assign opt_o = opt_q;

    // ----------------------------------------------------------------------
    // burst size per side
    // ----------------------------------------------------------------------
    // nearer boundary of the two sides
    assign c_to_pb = (r_to_pb_i > w_to_pb_i) ? w_to_pb_i : r_to_pb_i;

    assign r_bytes_possible_o = opt_q.decouple_rw ? r_to_pb_i : c_to_pb;
    assign w_bytes_possible_o = opt_q.decouple_rw ? w_to_pb_i : c_to_pb;

    // ----------------------------------------------------------------------
    // flow control
    // ----------------------------------------------------------------------
    assign both_ready = r_ready_i & w_ready_i;

    always_comb begin
        if (opt_q.decouple_rw) begin
            // each side paced by its own sink
            r_ena_o   = (r_ready_i & ~flush_i) | kill_i;
            w_ena_o   = (w_ready_i & ~flush_i) | kill_i;
            r_valid_o = r_valid_cur_i & r_ready_i & ~flush_i;
            w_valid_o = w_valid_cur_i & w_ready_i & ~flush_i;
        end else begin
            // lock step, one stalled sink stalls both
            r_ena_o   = (both_ready & ~flush_i) | kill_i;
            w_ena_o   = (both_ready & ~flush_i) | kill_i;
            r_valid_o = r_valid_cur_i & both_ready & ~flush_i;
            w_valid_o = w_valid_cur_i & both_ready & ~flush_i;
        end
    end

endmodule : burst_coupler

`default_nettype wire

// File: verilog/burst_formatter.sv
// purely combinational; fields are only meaningful while the matching valid strobe is high
`default_nettype none

module burst_formatter (
    input  burst_pkg::cursor_t           r_cur_i,
    input  burst_pkg::cursor_t           w_cur_i,
    input  legalizer_cfg_pkg::page_len_t r_num_bytes_i,
    input  legalizer_cfg_pkg::page_len_t w_num_bytes_i,
    input  logic                         w_done_i,
    output burst_pkg::r_req_t            r_req_o,
    output burst_pkg::w_req_t            w_req_o
);
    import legalizer_cfg_pkg::*;
    import burst_pkg::*;

    offset_t r_offset;
    offset_t w_offset;
    ax_req_t r_ax;
    ax_req_t w_ax;

    // ----------------------------------------------------------------------
    // address channel
    // ----------------------------------------------------------------------
    // beat aligned address, beats minus one, full bus size
    function automatic ax_req_t make_ax(input addr_t addr, input page_len_t num_bytes);
        page_len_t span;
        ax_req_t   ax;
        // bytes touched counting the leading offset
        span    = num_bytes + page_len_t'(addr[OffsetWidth-1:0]) - page_len_t'(1);
        ax.addr = {addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
        ax.len  = 8'(span >> OffsetWidth);
        ax.size = 3'(OffsetWidth);
        return ax;
    endfunction

    assign r_ax = make_ax(r_cur_i.addr, r_num_bytes_i);
    assign w_ax = make_ax(w_cur_i.addr, w_num_bytes_i);

    // ----------------------------------------------------------------------
    // data path hints
    // ----------------------------------------------------------------------
    assign r_offset = r_cur_i.addr[OffsetWidth-1:0];
    assign w_offset = w_cur_i.addr[OffsetWidth-1:0];

    // tailer is where the last byte ends inside its beat
    assign r_req_o.ax          = r_ax;
    assign r_req_o.r_dp.offset = r_offset;
    assign r_req_o.r_dp.tailer = OffsetWidth'(r_num_bytes_i + page_len_t'(r_offset));

    assign w_req_o.ax             = w_ax;
    assign w_req_o.w_dp.offset    = w_offset;
    assign w_req_o.w_dp.tailer    = OffsetWidth'(w_num_bytes_i + page_len_t'(w_offset));
    assign w_req_o.w_dp.num_beats = w_ax.len;
    assign w_req_o.w_dp.is_single = (w_ax.len == 8'd0);

    // write side finishing marks the end of the transfer
    assign w_req_o.last = w_done_i;

endmodule : burst_formatter

`default_nettype wire

// File: verilog/legalizer_top.sv
// one transfer in flight; r/w valid are high only while the matching ready is high
`default_nettype none

module legalizer_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  burst_pkg::xfer_req_t req_i,
    input  logic                 valid_i,
    output logic                 ready_o,
    output burst_pkg::r_req_t    r_req_o,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output burst_pkg::w_req_t    w_req_o,
    output logic                 w_valid_o,
    input  logic                 w_ready_i,
    input  logic                 flush_i,
    input  logic                 kill_i,
    output logic                 r_busy_o,
    output logic                 w_busy_o
);
    import legalizer_cfg_pkg::*;
    import burst_pkg::*;

    cursor_t   r_cur,      w_cur;
    page_len_t r_to_pb,    w_to_pb;
    page_len_t r_possible, w_possible;
    page_len_t r_num,      w_num;
    logic      r_done,     w_done;
    logic      r_ena,      w_ena;
    logic      accept;
    xfer_opt_t opt;

    // ----------------------------------------------------------------------
    // cursors
    // ----------------------------------------------------------------------
    // read side follows the source address
    side_cursor u_r_cursor (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .load_i           (accept),
        .load_addr_i      (req_i.src_addr),
        .load_len_i       (req_i.length),
        .ena_i            (r_ena),
        .kill_i           (kill_i),
        .reduce_i         (opt.src_reduce_len),
        .max_llen_i       (opt.src_max_llen),
        .bytes_possible_i (r_possible),
        .cur_o            (r_cur),
        .bytes_to_pb_o    (r_to_pb),
        .num_bytes_o      (r_num),
        .done_o           (r_done)
    );

    // write side follows the destination address
    side_cursor u_w_cursor (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .load_i           (accept),
        .load_addr_i      (req_i.dst_addr),
        .load_len_i       (req_i.length),
        .ena_i            (w_ena),
        .kill_i           (kill_i),
        .reduce_i         (opt.dst_reduce_len),
        .max_llen_i       (opt.dst_max_llen),
        .bytes_possible_i (w_possible),
        .cur_o            (w_cur),
        .bytes_to_pb_o    (w_to_pb),
        .num_bytes_o      (w_num),
        .done_o           (w_done)
    );

    // ----------------------------------------------------------------------
    // coupling and formatting
    // ----------------------------------------------------------------------
    burst_coupler u_coupler (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .valid_i            (valid_i),
        .opt_i              (req_i.opt),
        .r_to_pb_i          (r_to_pb),
        .w_to_pb_i          (w_to_pb),
        .r_done_i           (r_done),
        .w_done_i           (w_done),
        .r_valid_cur_i      (r_cur.valid),
        .w_valid_cur_i      (w_cur.valid),
        .r_ready_i          (r_ready_i),
        .w_ready_i          (w_ready_i),
        .flush_i            (flush_i),
        .kill_i             (kill_i),
        .opt_o              (opt),
        .accept_o           (accept),
        .ready_o            (ready_o),
        .r_bytes_possible_o (r_possible),
        .w_bytes_possible_o (w_possible),
        .r_ena_o            (r_ena),
        .w_ena_o            (w_ena),
        .r_valid_o          (r_valid_o),
        .w_valid_o          (w_valid_o)
    );

    burst_formatter u_formatter (
        .r_cur_i       (r_cur),
        .w_cur_i       (w_cur),
        .r_num_bytes_i (r_num),
        .w_num_bytes_i (w_num),
        .w_done_i      (w_done),
        .r_req_o       (r_req_o),
        .w_req_o       (w_req_o)
    );

    // a side is busy while its cursor holds work
    assign r_busy_o = r_cur.valid;
    assign w_busy_o = w_cur.valid;

endmodule : legalizer_top

`default_nettype wire

// File: tests/legalizer_properties.sv
// output rules of legalizer_top; sampled at the rising edge, off during reset
`default_nettype none

module legalizer_properties (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  logic              flush_i,
    input  logic              ready_o,
    input  burst_pkg::r_req_t r_req_o,
    input  logic              r_valid_o,
    input  burst_pkg::w_req_t w_req_o,
    input  logic              w_valid_o,
    input  logic              r_busy_o,
    input  logic              w_busy_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import legalizer_cfg_pkg::*;

    // ----------------------------------------------------------------------
    // output rules
    // ----------------------------------------------------------------------
    // flush holds both channels quiet
    a_flush_quiet : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flush_i |-> !r_valid_o && !w_valid_o)
        else $error("burst emitted while flush is high");

    // addresses leave beat aligned
    a_r_aligned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r_valid_o |-> r_req_o.ax.addr[OffsetWidth-1:0] == '0)
        else $error("read address not beat aligned");

    a_w_aligned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        w_valid_o |-> w_req_o.ax.addr[OffsetWidth-1:0] == '0)
        else $error("write address not beat aligned");

    // ready only on the final bursts, so with no new transfer each side is idle next
    a_r_ready_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_o && !valid_i |=> !r_busy_o)
        else $error("read side still busy after ready without a new transfer");

    a_w_ready_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_o && !valid_i |=> !w_busy_o)
        else $error("write side still busy after ready without a new transfer");

endmodule : legalizer_properties

bind legalizer_top legalizer_properties u_properties (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (valid_i),
    .flush_i   (flush_i),
    .ready_o   (ready_o),
    .r_req_o   (r_req_o),
    .r_valid_o (r_valid_o),
    .w_req_o   (w_req_o),
    .w_valid_o (w_valid_o),
    .r_busy_o  (r_busy_o),
    .w_busy_o  (w_busy_o)
);

`default_nettype wire

// File: tests/legalizer_tb.sv
// random transfers of 1 to 2500 bytes under random back-pressure; $fatal at the first mismatch
`default_nettype none

module legalizer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import legalizer_cfg_pkg::*;
    import burst_pkg::*;

    localparam int unsigned NumRandom    = 60;
    localparam int unsigned SendTimeout  = 5000;
    localparam int unsigned DrainTimeout = 100000;

    logic      clk_i;
    logic      arst_n_i;
    xfer_req_t req_i;
    logic      valid_i;
    logic      ready_o;
    r_req_t    r_req_o;
    logic      r_valid_o;
    logic      r_ready_i;
    w_req_t    w_req_o;
    logic      w_valid_o;
    logic      w_ready_i;
    logic      flush_i;
    logic      kill_i;
    logic      r_busy_o;
    logic      w_busy_o;

    integer      seed;
    // 0 random sink readies, 1 both high, 2 both low
    int          bp_mode;
    logic        accepted;
    int unsigned num_r;
    int unsigned num_w;
    r_req_t      exp_r[$];
    w_req_t      exp_w[$];

    legalizer_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // error handling
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic stop_run(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        abort_run();
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    // full page is 256 beats, a reduced one 2^llen beats, never above 1 KiB
    function automatic int unsigned page_bytes(input logic reduce, input llen_t llen);
        int unsigned width;
        width = reduce ? OffsetWidth + 32'(llen) : OffsetWidth + 8;
        if (width > PageAddrWidth)
            width = PageAddrWidth;
        return 32'd1 << width;
    endfunction

    task automatic push_r(input addr_t addr, input int unsigned n);
        r_req_t      r;
        int unsigned off;
        off           = 32'(addr) % StrbWidth;
        r.ax.addr     = addr - addr_t'(off);
        // beats touched minus one, counting the leading offset
        r.ax.len      = 8'((n + off - 1) / StrbWidth);
        r.ax.size     = 3'(OffsetWidth);
        r.r_dp.offset = offset_t'(off);
        r.r_dp.tailer = offset_t'((n + off) % StrbWidth);
        exp_r.push_back(r);
    endtask

    task automatic push_w(input addr_t addr, input int unsigned n, input logic last);
        w_req_t      w;
        int unsigned off;
        off              = 32'(addr) % StrbWidth;
        w.ax.addr        = addr - addr_t'(off);
        w.ax.len         = 8'((n + off - 1) / StrbWidth);
        w.ax.size        = 3'(OffsetWidth);
        w.w_dp.offset    = offset_t'(off);
        w.w_dp.tailer    = offset_t'((n + off) % StrbWidth);
        w.w_dp.num_beats = w.ax.len;
        w.w_dp.is_single = (w.ax.len == 8'd0);
        w.last           = last;
        exp_w.push_back(w);
    endtask

    // one side of a transfer; when coupled, the other side's boundary also cuts
    task automatic split_side(input logic is_w, input addr_t own, input addr_t other,
                              input int unsigned own_pg, input int unsigned other_pg,
                              input logic coupled, input int unsigned length);
        int unsigned left;
        int unsigned pb;
        int unsigned other_pb;
        int unsigned n;
        left = length;
        while (left > 0) begin
            pb       = own_pg - (32'(own) % own_pg);
            other_pb = other_pg - (32'(other) % other_pg);
            if (coupled && other_pb < pb)
                pb = other_pb;
            n = (left <= pb) ? left : pb;
            if (is_w)
                push_w(own, n, n == left);
            else
                push_r(own, n);
            own   = own + addr_t'(n);
            other = other + addr_t'(n);
            left  = left - n;
        end
    endtask

    task automatic model_xfer(input xfer_req_t x);
        int unsigned r_pg;
        int unsigned w_pg;
        r_pg = page_bytes(x.opt.src_reduce_len, x.opt.src_max_llen);
        w_pg = page_bytes(x.opt.dst_reduce_len, x.opt.dst_max_llen);
        split_side(1'b0, x.src_addr, x.dst_addr, r_pg, w_pg, !x.opt.decouple_rw, 32'(x.length));
        split_side(1'b1, x.dst_addr, x.src_addr, w_pg, r_pg, !x.opt.decouple_rw, 32'(x.length));
    endtask

    // ----------------------------------------------------------------------
    // cycle handling
    // ----------------------------------------------------------------------
    // outputs are settled at the falling edge and hold until the next rising edge
    task automatic observe();
        if (flush_i)
            check(64'({r_valid_o, w_valid_o, ready_o}), '0, "valid or ready during flush");
        if (r_valid_o) begin
            num_r++;
            if (exp_r.size() == 0)
                stop_run("read burst emitted while none was expected");
            else
                check(64'(r_req_o), 64'(exp_r.pop_front()), "read burst");
        end
        if (w_valid_o) begin
            num_w++;
            if (exp_w.size() == 0)
                stop_run("write burst emitted while none was expected");
            else
                check(64'(w_req_o), 64'(exp_w.pop_front()), "write burst");
        end
        // acceptance at the coming edge, after the last bursts of the previous transfer
        if (valid_i && ready_o) begin
            accepted = 1'b1;
            model_xfer(req_i);
        end
    endtask

    task automatic tick();
        @(negedge clk_i);
        observe();
        @(posedge clk_i);
        #1;
        if (bp_mode == 0) begin
            r_ready_i = ($unsigned($random(seed)) % 4) != 0;
            w_ready_i = ($unsigned($random(seed)) % 4) != 0;
        end else begin
            r_ready_i = (bp_mode == 1);
            w_ready_i = (bp_mode == 1);
        end
    endtask

    task automatic make_xfer(output xfer_req_t x, input logic decouple, input logic reduce);
        x.src_addr           = addr_t'($random(seed));
        x.dst_addr           = addr_t'($random(seed));
        x.length             = len_t'(32'd1 + ($unsigned($random(seed)) % 32'd2500));
        x.opt.decouple_rw    = decouple;
        x.opt.src_reduce_len = reduce && (($unsigned($random(seed)) % 2) == 1);
        x.opt.dst_reduce_len = reduce && (($unsigned($random(seed)) % 2) == 1);
        x.opt.src_max_llen   = llen_t'($unsigned($random(seed)));
        x.opt.dst_max_llen   = llen_t'($unsigned($random(seed)));
    endtask

    // hold the request until the DUT takes it
    task automatic send(input xfer_req_t x);
        int unsigned t;
        req_i    = x;
        valid_i  = 1'b1;
        accepted = 1'b0;
        t        = 0;
        while (!accepted) begin
            if (t == SendTimeout)
                stop_run("transfer was not accepted in time");
            tick();
            t++;
        end
        valid_i = 1'b0;
    endtask

    task automatic drain();
        int unsigned t;
        t = 0;
        while (exp_r.size() != 0 || exp_w.size() != 0 || r_busy_o || w_busy_o) begin
            if (t == DrainTimeout)
                stop_run("expected bursts did not all appear in time");
            tick();
            t++;
        end
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        xfer_req_t x;
        xfer_req_t y;
        seed      = 32'h5aa8d7ea;
        arst_n_i  = 1'b0;
        req_i     = '0;
        valid_i   = 1'b0;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        flush_i   = 1'b0;
        kill_i    = 1'b0;
        bp_mode   = 1;
        accepted  = 1'b0;
        num_r     = 0;
        num_w     = 0;
        repeat (16) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check(64'({ready_o, r_valid_o, w_valid_o, r_busy_o, w_busy_o}), 64'(5'b10000),
              "outputs after reset");

        // back to back transfers, coupled and decoupled, plain pages first, then reduced
        bp_mode = 0;
        for (int i = 0; i < NumRandom; i++) begin
            make_xfer(x, (i % 2) == 1, i >= NumRandom / 2);
            send(x);
        end
        drain();

        // flush in the middle of a long transfer while the next one waits
        make_xfer(x, 1'b0, 1'b1);
        x.length             = len_t'(3000);
        x.opt.src_reduce_len = 1'b1;
        x.opt.src_max_llen   = llen_t'(2);
        send(x);
        repeat (5) tick();
        make_xfer(y, 1'b1, 1'b0);
        req_i   = y;
        valid_i = 1'b1;
        flush_i = 1'b1;
        repeat (12) tick();
        flush_i = 1'b0;
        send(y);
        drain();

        // kill a long coupled transfer with both sinks stalled
        send(x);
        repeat (5) tick();
        bp_mode = 2;
        tick();
        check(64'({r_busy_o, w_busy_o}), 64'(2'b11), "busy before kill");
        kill_i = 1'b1;
        tick();
        kill_i = 1'b0;
        exp_r.delete();
        exp_w.delete();
        check(64'({r_busy_o, w_busy_o}), '0, "busy after kill");
        bp_mode = 0;
        make_xfer(y, 1'b0, 1'b1);
        send(y);
        drain();

        $display("checked %0d read and %0d write bursts", num_r, num_w);
        $display("** PASS **");
        $finish;
    end

endmodule : legalizer_tb

`default_nettype wire

// File: src.f
verilog/legalizer_cfg_pkg.sv
verilog/burst_pkg.sv
verilog/side_cursor.sv
verilog/burst_coupler.sv
verilog/burst_formatter.sv
verilog/legalizer_top.sv
tests/legalizer_properties.sv
tests/legalizer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the legalizer testbench with Verilator and run it
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module legalizer_tb \
    -f src.f \
    -o legalizer_sim

./obj_dir/legalizer_sim 2>&1 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
